/* ahbBus_defs.svh */
// Global sizing macros for the external bus unit
//   BUS_XLEN      AHB data width and load/store word
//   BUS_AWIDTH    AHB address width
//   BUS_MEMWORDS  Depth of the testbench slave memory

`ifndef AHBBUS_DEFS_SVH
`define AHBBUS_DEFS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

`define BUS_XLEN   64             // HRDATA / HWDATA width, also the LSU word
`define BUS_AWIDTH 32             // HADDR width

//////////////////////////////////////////////////
// Test memory
//////////////////////////////////////////////////

// Word count of the behavioral slave
// Index is taken from HADDR above the byte offset
`define BUS_MEMWORDS 64

`endif

/* ahbBusPkg.sv */
// Shared types of the external bus unit
//   Request code, AHB transfer type and controller state
//   Instruction, data, strobe and address word types

`include "ahbBus_defs.svh"

package ahbBusPkg;

  // Request from the IFU or LSU, held until BusStall falls
  typedef enum logic [1:0] {
    BusNone  = 2'b00,             // No request
    BusWrite = 2'b01,             // Store
    BusRead  = 2'b10              // Load or fetch
  } busRwT;

  // Only single transfers, so SEQ and BUSY never appear
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } hTransT;

  // Two-phase transfer controller
  typedef enum logic [1:0] {
    AdrPhase,                     // Waiting to issue, or issuing NONSEQ
    DataPhase,                    // Address accepted, waiting on HREADY
    MemDone                       // Finished, parked while Stall is high
  } busStateT;

  typedef logic [31:0]                ifuWordT;   // Instruction word
  typedef logic [`BUS_XLEN-1:0]       lsuWordT;   // Load/store word, full bus width
  typedef logic [`BUS_XLEN/8-1:0]     byteMaskT;  // One strobe per byte lane
  typedef logic [`BUS_AWIDTH-1:0]     adrT;       // Byte address

endpackage

/* busFsm.sv */
// Two-phase AHB-Lite transfer controller
//   Issues one NONSEQ per request, then waits out the data phase
//   Drives HTRANS, HWRITE, CaptureEn, BusStall and BusCommitted
//   Parks in MemDone while the pipeline is stalled

`timescale 1ns/100ps

module busFsm (
  input  logic                HCLK,
  input  logic                rstN,
  input  logic                HREADY,        // Gated by the arbiter, 0 when not granted
  input  logic                Stall,         // Pipeline stalled, hold the finished transfer
  input  logic                Flush,         // Pipeline flushed, no new transfer
  input  ahbBusPkg::busRwT    BusRW,         // Held until BusStall is low
  output ahbBusPkg::hTransT   HTRANS,
  output logic                HWRITE,
  output logic                CaptureEn,     // Load the read data register
  output logic                BusStall,      // Request still in flight
  output logic                BusCommitted   // Data phase, not safe to abandon
);

  import ahbBusPkg::*;

  busStateT state;
  busStateT nextState;
  logic     request;                         // Requester is asking for a transfer

  assign request = (BusRW != BusNone);

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (!rstN) state <= AdrPhase;
    else       state <= nextState;
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    nextState = state;                       // HREADY low holds the phase
    case (state)
      AdrPhase: begin
        if (request && !Flush && HREADY) nextState = DataPhase;  // NONSEQ accepted
      end
      DataPhase: begin
        if (HREADY) nextState = MemDone;     // Data phase ends on first ready
      end
      MemDone: begin
        // Stay parked so a held request does not restart
        if (!Stall) nextState = AdrPhase;
      end
      default: nextState = AdrPhase;
    endcase
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Address phase is combinational from the request
  assign HTRANS = (state == AdrPhase && request && !Flush) ? NONSEQ : IDLE;
  assign HWRITE = (BusRW == BusWrite);

  // Read data arrives with the ready that ends the data phase
  assign CaptureEn    = (state == DataPhase) && HREADY && (BusRW == BusRead);
  assign BusStall     = request && (state != MemDone);
  assign BusCommitted = (state == DataPhase);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Direction of the outstanding transfer is fixed once the address is taken
  assert property (@(posedge HCLK) disable iff (!rstN)
    BusCommitted |-> $stable(BusRW))
    else $error("busFsm request changed during data phase");

  // Requester must keep BusRW held through the data phase
  assert property (@(posedge HCLK) disable iff (!rstN)
    BusCommitted |-> BusStall)
    else $error("busFsm request dropped while committed");

endmodule

/* ahbInterface.sv */
// Bus interface of one requester
//   busFsm transfer controller
//   Enabled capture register for read data
//   One-cycle delay of store data and strobes on the data side

`timescale 1ns/100ps

module ahbInterface #(
  parameter type fetchT   = ahbBusPkg::lsuWordT,  // Width of the captured read word
  parameter bit  hasWrite = 1'b1                  // 1 data side, 0 instruction side
) (
  input  logic                  HCLK,
  input  logic                  rstN,
  // AHB side
  input  logic                  HREADY,           // Gated ready from the arbiter
  input  ahbBusPkg::lsuWordT    HRDATA,
  output ahbBusPkg::hTransT     HTRANS,
  output logic                  HWRITE,
  output ahbBusPkg::lsuWordT    HWDATA,           // Valid in the data phase
  output ahbBusPkg::byteMaskT   HWSTRB,
  // Requester side
  input  logic                  Stall,
  input  logic                  Flush,
  input  ahbBusPkg::busRwT      BusRW,
  input  ahbBusPkg::byteMaskT   ByteMask,         // Store byte enables
  input  ahbBusPkg::lsuWordT    WriteData,        // Store data
  output logic                  BusStall,
  output logic                  BusCommitted,
  output fetchT                 FetchBuffer       // Read data, valid once BusStall falls
);

  import ahbBusPkg::*;

  localparam int FetchLen = $bits(fetchT);        // 32 for IFU, bus width for LSU

  logic captureEn;

  // Transfer controller
  busFsm fsm (
    .HCLK         (HCLK),
    .rstN         (rstN),
    .HREADY       (HREADY),
    .Stall        (Stall),
    .Flush        (Flush),
    .BusRW        (BusRW),
    .HTRANS       (HTRANS),
    .HWRITE       (HWRITE),
    .CaptureEn    (captureEn),
    .BusStall     (BusStall),
    .BusCommitted (BusCommitted)
  );

  // Read capture, low lanes only on the instruction side
  always_ff @(posedge HCLK) begin
    if (captureEn) FetchBuffer <= fetchT'(HRDATA[FetchLen-1:0]);
  end

  //////////////////////////////////////////////////
  // Store path
  //////////////////////////////////////////////////

  if (hasWrite) begin : genWrite
    // Address phase data moves one cycle into the data phase
    always_ff @(posedge HCLK) begin
      HWDATA <= WriteData;
      HWSTRB <= ByteMask;
    end
  end else begin : genNoWrite
    assign HWDATA = '0;                           // Fetch side never writes
    assign HWSTRB = '0;

    assert property (@(posedge HCLK) disable iff (!rstN)
      BusRW != BusWrite)
      else $error("ahbInterface write requested on read-only side");
  end

endmodule

/* busArbiter.sv */
// Arbiter for the shared AHB master port
//   Data side wins when both request at idle
//   Grant locks on NONSEQ accept, releases at end of data phase
//   Muxes the address phase and gates HREADY per requester

`timescale 1ns/100ps

module busArbiter (
  input  logic                HCLK,
  input  logic                rstN,
  input  logic                HREADY,        // From the slave
  // Instruction interface
  input  ahbBusPkg::hTransT   ifuHTRANS,
  input  logic                ifuHWRITE,
  input  ahbBusPkg::adrT      ifuAdr,
  output logic                ifuHREADY,
  // Data interface
  input  ahbBusPkg::hTransT   lsuHTRANS,
  input  logic                lsuHWRITE,
  input  ahbBusPkg::adrT      lsuAdr,
  output logic                lsuHREADY,
  // Shared address phase
  output ahbBusPkg::adrT      HADDR,
  output ahbBusPkg::hTransT   HTRANS,
  output logic                HWRITE
);

  import ahbBusPkg::*;

  logic lockQ;                               // A transfer owns the bus
  logic ownerLsuQ;                           // Owner of the locked transfer
  logic grantLsu;                            // Current grant, 0 means IFU
  logic ifuReq;
  logic lsuReq;
  logic accept;                              // NONSEQ taken by the slave

  assign ifuReq = (ifuHTRANS == NONSEQ);
  assign lsuReq = (lsuHTRANS == NONSEQ);

  //////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////

  // Locked owner keeps the bus, else LSU first
  // Idle bus defaults to the data side
  always_comb begin
    if (lockQ) grantLsu = ownerLsuQ;
    else       grantLsu = lsuReq || !ifuReq;
  end

  //////////////////////////////////////////////////
  // Lock state
  //////////////////////////////////////////////////

  assign accept = HREADY && (HTRANS == NONSEQ);

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      lockQ     <= 1'b0;
      ownerLsuQ <= 1'b0;
    end else if (!lockQ) begin
      if (accept) begin                      // Address phase done, hold through data
        lockQ     <= 1'b1;
        ownerLsuQ <= grantLsu;
      end
    end else if (HREADY) begin
      lockQ <= 1'b0;                         // Data phase ends
    end
  end

  //////////////////////////////////////////////////
  // Address phase mux and ready gating
  //////////////////////////////////////////////////

  assign HADDR  = grantLsu ? lsuAdr    : ifuAdr;
  assign HTRANS = grantLsu ? lsuHTRANS : ifuHTRANS;
  assign HWRITE = grantLsu ? lsuHWRITE : ifuHWRITE;

  // Loser sees 0 and waits in AdrPhase
  assign lsuHREADY = HREADY &&  grantLsu;
  assign ifuHREADY = HREADY && !grantLsu;

  // Owner sits in its data phase while locked, so no NONSEQ may reach the bus
  assert property (@(posedge HCLK) disable iff (!rstN)
    (HTRANS == NONSEQ) |-> !lockQ)
    else $error("busArbiter NONSEQ issued while a transfer holds the bus");

endmodule

/* memBus.sv */
// External bus unit top level
//   Instruction and data bus interfaces
//   Arbiter sharing one AHB-Lite master port

`timescale 1ns/100ps

module memBus (
  input  logic                  HCLK,
  input  logic                  rstN,
  // AHB slave response
  input  logic                  HREADY,
  input  ahbBusPkg::lsuWordT    HRDATA,
  // AHB master
  output ahbBusPkg::adrT        HADDR,
  output ahbBusPkg::hTransT     HTRANS,
  output logic                  HWRITE,
  output ahbBusPkg::lsuWordT    HWDATA,
  output ahbBusPkg::byteMaskT   HWSTRB,
  // Instruction fetch
  input  ahbBusPkg::busRwT      ifuBusRW,
  input  ahbBusPkg::adrT        ifuAdr,
  input  logic                  ifuStall,
  input  logic                  ifuFlush,
  output logic                  ifuBusStall,
  output logic                  ifuBusCommitted,
  output ahbBusPkg::ifuWordT    ifuFetchBuffer,
  // Load/store
  input  ahbBusPkg::busRwT      lsuBusRW,
  input  ahbBusPkg::adrT        lsuAdr,
  input  logic                  lsuStall,
  input  logic                  lsuFlush,
  input  ahbBusPkg::byteMaskT   lsuByteMask,
  input  ahbBusPkg::lsuWordT    lsuWriteData,
  output logic                  lsuBusStall,
  output logic                  lsuBusCommitted,
  output ahbBusPkg::lsuWordT    lsuFetchBuffer
);

  import ahbBusPkg::*;

  hTransT ifuHTRANS;
  hTransT lsuHTRANS;
  logic   ifuHWRITE;
  logic   lsuHWRITE;
  logic   ifuHREADY;                         // Gated by the arbiter
  logic   lsuHREADY;

  // Fetch side, read only, 32-bit capture
  ahbInterface #(.fetchT(ifuWordT), .hasWrite(1'b0)) ifuBus (
    .HCLK(HCLK), .rstN(rstN), .HREADY(ifuHREADY), .HRDATA(HRDATA),
    .HTRANS(ifuHTRANS), .HWRITE(ifuHWRITE), .HWDATA(), .HWSTRB(),
    .Stall(ifuStall), .Flush(ifuFlush), .BusRW(ifuBusRW),
    .ByteMask('0), .WriteData('0),           // No stores from fetch
    .BusStall(ifuBusStall), .BusCommitted(ifuBusCommitted), .FetchBuffer(ifuFetchBuffer)
  );

  // Data side owns the write data lanes
  ahbInterface #(.fetchT(lsuWordT), .hasWrite(1'b1)) lsuBus (
    .HCLK(HCLK), .rstN(rstN), .HREADY(lsuHREADY), .HRDATA(HRDATA),
    .HTRANS(lsuHTRANS), .HWRITE(lsuHWRITE), .HWDATA(HWDATA), .HWSTRB(HWSTRB),
    .Stall(lsuStall), .Flush(lsuFlush), .BusRW(lsuBusRW),
    .ByteMask(lsuByteMask), .WriteData(lsuWriteData),
    .BusStall(lsuBusStall), .BusCommitted(lsuBusCommitted), .FetchBuffer(lsuFetchBuffer)
  );

  busArbiter arb (
    .HCLK(HCLK), .rstN(rstN), .HREADY(HREADY),
    .ifuHTRANS(ifuHTRANS), .ifuHWRITE(ifuHWRITE), .ifuAdr(ifuAdr), .ifuHREADY(ifuHREADY),
    .lsuHTRANS(lsuHTRANS), .lsuHWRITE(lsuHWRITE), .lsuAdr(lsuAdr), .lsuHREADY(lsuHREADY),
    .HADDR(HADDR), .HTRANS(HTRANS), .HWRITE(HWRITE)
  );

endmodule

/* tbAhbMemory.sv */
// Behavioral AHB-Lite slave memory for the testbench
//   Single transfers with 0 to 3 random wait states from a preloaded table
//   Byte-strobed writes, combinational read data
//   Count of accepted NONSEQ transfers

`timescale 1ns/100ps
`include "ahbBus_defs.svh"

module tbAhbMemory (
  input  logic                  HCLK,
  input  logic                  rstN,
  input  ahbBusPkg::adrT        HADDR,
  input  ahbBusPkg::hTransT     HTRANS,
  input  logic                  HWRITE,
  input  ahbBusPkg::lsuWordT    HWDATA,       // Valid in the data phase
  input  ahbBusPkg::byteMaskT   HWSTRB,
  output logic                  HREADY,
  output ahbBusPkg::lsuWordT    HRDATA
);

  import ahbBusPkg::*;

  localparam int OffBits   = $clog2(`BUS_XLEN/8);  // Byte offset inside a word
  localparam int IdxBits   = $clog2(`BUS_MEMWORDS);
  localparam int WaitSlots = 64;                   // Wait-state entries, reused in turn

  lsuWordT              words [`BUS_MEMWORDS];   // Preloaded by the testbench top
  logic [1:0]           waitTable [WaitSlots];   // Random wait states, also preloaded
  logic                 busy;                    // Data phase in progress
  logic                 writeQ;
  logic [IdxBits-1:0]   idxQ;                    // Word of the pending transfer
  logic [1:0]           waitCnt;                 // Wait states still to insert
  int                   xferCount;               // NONSEQ transfers seen

  assign HREADY = !busy || (waitCnt == 2'd0);
  assign HRDATA = (busy && !writeQ) ? words[idxQ] : '0;

  //////////////////////////////////////////////////
  // Address and data phase tracking
  //////////////////////////////////////////////////

  always @(posedge HCLK) begin
    if (!rstN) begin
      busy      <= 1'b0;
      writeQ    <= 1'b0;
      idxQ      <= '0;
      waitCnt   <= 2'd0;
      xferCount <= 0;
    end else if (HREADY) begin
      // Last cycle of a write data phase, merge enabled lanes
      if (busy && writeQ) begin
        for (int b = 0; b < `BUS_XLEN/8; b++) begin
          if (HWSTRB[b]) words[idxQ][8*b +: 8] <= HWDATA[8*b +: 8];
        end
      end
      if (HTRANS == NONSEQ) begin                // New address phase accepted
        busy      <= 1'b1;
        writeQ    <= HWRITE;
        idxQ      <= HADDR[OffBits +: IdxBits];
        waitCnt   <= waitTable[xferCount % WaitSlots];
        xferCount <= xferCount + 1;
      end else begin
        busy <= 1'b0;
      end
    end else begin
      waitCnt <= waitCnt - 2'd1;                 // Wait state
    end
  end

endmodule

/* tbMemBus.sv */
// Testbench for the external bus unit
//   Clock, reset, slave memory preload
//   Stimulus table of reads, writes, flush, stall and arbitration rows
//   One report line per test, closing counts

`timescale 1ns/100ps
`include "ahbBus_defs.svh"

module tbMemBus;

  import ahbBusPkg::*;

  localparam int         NumRows       = 14;
  localparam int         TimeoutCycles = 50;
  localparam int         WaitSlots     = 64;   // Size of the slave's wait-state table
  localparam logic [1:0] SideLsu       = 2'd0;
  localparam logic [1:0] SideIfu       = 2'd1;
  localparam logic [1:0] SideBoth      = 2'd2;  // LSU on adr, IFU on adr2

  typedef struct packed {
    logic [1:0] side;
    busRwT      rw;
    adrT        adr;
    adrT        adr2;                           // IFU address of a both row
    lsuWordT    wdata;
    byteMaskT   mask;
    logic       flush;
    logic       stall;
    lsuWordT    expData;                        // Single side, or LSU of a both row
    lsuWordT    expIfu;                         // IFU of a both row
  } rowT;

  logic     HCLK;
  logic     rstN;
  logic     HREADY;
  lsuWordT  HRDATA;
  adrT      HADDR;
  hTransT   HTRANS;
  logic     HWRITE;
  lsuWordT  HWDATA;
  byteMaskT HWSTRB;
  busRwT    ifuBusRW;
  adrT      ifuAdr;
  logic     ifuStall;
  logic     ifuFlush;
  logic     ifuBusStall;
  logic     ifuBusCommitted;
  ifuWordT  ifuFetchBuffer;
  busRwT    lsuBusRW;
  adrT      lsuAdr;
  logic     lsuStall;
  logic     lsuFlush;
  logic     lsuBusStall;
  logic     lsuBusCommitted;
  byteMaskT lsuByteMask;
  lsuWordT  lsuWriteData;
  lsuWordT  lsuFetchBuffer;

  rowT rows [NumRows];
  int  errors;
  int  testErrors;
  int  testsFailed;

  memBus      uut   (.*);
  tbAhbMemory slave (.*);

  always #4 HCLK = ~HCLK;                       // 8 ns period

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Odd multipliers, so every index bit reaches both halves
  function automatic lsuWordT preloadWord(input int i);
    logic [31:0] k;
    k = i;
    return {(k * 32'h9E37_79B9) ^ 32'hC001_D00D, (k * 32'h0101_0101) + 32'h1357_9BDF};
  endfunction

  function automatic lsuWordT mergeBytes(input lsuWordT oldWord, input lsuWordT newWord,
                                         input byteMaskT mask);
    lsuWordT res;
    res = oldWord;
    for (int b = 0; b < `BUS_XLEN/8; b++) begin
      if (mask[b]) res[8*b +: 8] = newWord[8*b +: 8];
    end
    return res;
  endfunction

  function automatic adrT wordAdr(input int i);
    return adrT'(i * (`BUS_XLEN/8));
  endfunction

  function automatic lsuWordT lowWord(input lsuWordT w);
    return lsuWordT'(w[31:0]);                  // What a fetch returns
  endfunction

  function automatic rowT makeRow(input logic [1:0] side, input busRwT rw, input adrT adr,
                                  input adrT adr2, input lsuWordT wdata, input byteMaskT mask,
                                  input logic flush, input logic stall,
                                  input lsuWordT expData, input lsuWordT expIfu);
    return '{side, rw, adr, adr2, wdata, mask, flush, stall, expData, expIfu};
  endfunction

  function automatic string rowName(input rowT r);
    string s;
    s = (r.side == SideLsu) ? "lsu" : (r.side == SideIfu) ? "ifu" : "lsu+ifu";
    s = {s, (r.rw == BusWrite) ? " write" : " read"};
    if (r.flush) s = {s, " flushed"};
    if (r.stall) s = {s, " stalled"};
    return s;
  endfunction

  //////////////////////////////////////////////////
  // Reporting and waiting
  //////////////////////////////////////////////////

  task automatic reportMismatch(input string name, input lsuWordT got, input lsuWordT exp);
    $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    errors++;
    testErrors++;
  endtask

  task automatic noteError(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
    testErrors++;
  endtask

  // Done cycle per side, -1 on timeout; drops BusRW after done unless held
  task automatic waitDone(input bit lsuOn, input bit ifuOn, input bit holdOn,
                          output int lsuAt, output int ifuAt);
    int cycles;
    bit lsuDone;
    bit ifuDone;
    bit lsuCommit;                              // Data phase seen on BusCommitted
    bit ifuCommit;
    cycles    = 0;
    lsuDone   = !lsuOn;
    ifuDone   = !ifuOn;
    lsuCommit = 1'b0;
    ifuCommit = 1'b0;
    lsuAt     = -1;
    ifuAt     = -1;
    while (!(lsuDone && ifuDone) && cycles < TimeoutCycles) begin
      @(negedge HCLK);                          // Outputs settled
      if (lsuBusCommitted === 1'b1) lsuCommit = 1'b1;
      if (ifuBusCommitted === 1'b1) ifuCommit = 1'b1;
      if (!lsuDone && !lsuBusStall) begin
        lsuDone = 1'b1;
        lsuAt   = cycles;
      end
      if (!ifuDone && !ifuBusStall) begin
        ifuDone = 1'b1;
        ifuAt   = cycles;
      end
      @(posedge HCLK);
      if (lsuOn && lsuDone && !holdOn) lsuBusRW <= BusNone;
      if (ifuOn && ifuDone && !holdOn) ifuBusRW <= BusNone;
      cycles++;
    end
    if (!lsuDone) noteError("lsuBusStall stayed high for 50 cycles, transfer never ended");
    if (!ifuDone) noteError("ifuBusStall stayed high for 50 cycles, transfer never ended");
    if (lsuOn && lsuAt >= 0 && !lsuCommit)
      noteError("lsuBusCommitted never rose before the transfer ended");
    if (ifuOn && ifuAt >= 0 && !ifuCommit)
      noteError("ifuBusCommitted never rose before the transfer ended");
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic buildRows();
    lsuWordT wr5;
    lsuWordT wr6;
    wr5 = 64'h0123_4567_89AB_CDEF;
    wr6 = 64'hFEED_FACE_5EED_0B0E;
    rows[0]  = makeRow(SideLsu, BusRead, wordAdr(3), '0, '0, '0, 1'b0, 1'b0, preloadWord(3), '0);
    rows[1]  = makeRow(SideIfu, BusRead, wordAdr(7), '0, '0, '0, 1'b0, 1'b0,
                       lowWord(preloadWord(7)), '0);
    rows[2]  = makeRow(SideLsu, BusRead, wordAdr(12), '0, '0, '0, 1'b0, 1'b0,
                       preloadWord(12), '0);
    rows[3]  = makeRow(SideIfu, BusRead, wordAdr(21), '0, '0, '0, 1'b0, 1'b0,
                       lowWord(preloadWord(21)), '0);
    rows[4]  = makeRow(SideLsu, BusWrite, wordAdr(5), '0, wr5, 8'hA5, 1'b0, 1'b0, '0, '0);
    rows[5]  = makeRow(SideLsu, BusRead, wordAdr(5), '0, '0, '0, 1'b0, 1'b0,
                       mergeBytes(preloadWord(5), wr5, 8'hA5), '0);
    rows[6]  = makeRow(SideLsu, BusWrite, wordAdr(6), '0, wr6, 8'hFF, 1'b0, 1'b0, '0, '0);
    rows[7]  = makeRow(SideIfu, BusRead, wordAdr(6), '0, '0, '0, 1'b0, 1'b0, lowWord(wr6), '0);
    rows[8]  = makeRow(SideLsu, BusRead, wordAdr(17), '0, '0, '0, 1'b1, 1'b0, '0, '0);
    rows[9]  = makeRow(SideIfu, BusRead, wordAdr(18), '0, '0, '0, 1'b1, 1'b0, '0, '0);
    rows[10] = makeRow(SideBoth, BusRead, wordAdr(9), wordAdr(30), '0, '0, 1'b0, 1'b0,
                       preloadWord(9), lowWord(preloadWord(30)));
    rows[11] = makeRow(SideBoth, BusRead, wordAdr(63), wordAdr(0), '0, '0, 1'b0, 1'b0,
                       preloadWord(63), lowWord(preloadWord(0)));
    rows[12] = makeRow(SideLsu, BusRead, wordAdr(40), '0, '0, '0, 1'b0, 1'b1,
                       preloadWord(40), '0);
    rows[13] = makeRow(SideIfu, BusRead, wordAdr(50), '0, '0, '0, 1'b0, 1'b1,
                       lowWord(preloadWord(50)), '0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rowT     r;
    int      countAt;
    int      expXfers;
    int      lsuAt;
    int      ifuAt;
    bit      lsuOn;
    bit      ifuOn;
    lsuWordT expIfu;
    HCLK = 1'b0;
    rstN = 1'b0;
    ifuBusRW = BusNone;
    ifuAdr   = '0;
    ifuStall = 1'b0;
    ifuFlush = 1'b0;
    lsuBusRW = BusNone;
    lsuAdr   = '0;
    lsuStall = 1'b0;
    lsuFlush = 1'b0;
    lsuByteMask  = '0;
    lsuWriteData = '0;
    errors      = 0;
    testErrors  = 0;
    testsFailed = 0;
    void'($urandom(32'hb2c4da3c));
    for (int i = 0; i < `BUS_MEMWORDS; i++) slave.words[i] = preloadWord(i);
    for (int i = 0; i < WaitSlots; i++) slave.waitTable[i] = 2'($urandom_range(3, 0));
    buildRows();
    repeat (5) @(posedge HCLK);
    rstN <= 1'b1;

    // Idle state straight out of reset
    @(negedge HCLK);
    if (HTRANS !== IDLE) reportMismatch("HTRANS", lsuWordT'(HTRANS), lsuWordT'(IDLE));
    if (lsuBusStall !== 1'b0) reportMismatch("lsuBusStall", lsuWordT'(lsuBusStall), '0);
    if (ifuBusStall !== 1'b0) reportMismatch("ifuBusStall", lsuWordT'(ifuBusStall), '0);
    if (lsuBusCommitted !== 1'b0) reportMismatch("lsuBusCommitted", lsuWordT'(lsuBusCommitted), '0);
    if (ifuBusCommitted !== 1'b0) reportMismatch("ifuBusCommitted", lsuWordT'(ifuBusCommitted), '0);
    if (uut.arb.lockQ !== 1'b0) reportMismatch("arb.lockQ", lsuWordT'(uut.arb.lockQ), '0);
    $display("Test 0 reset: %0d errors", testErrors);
    if (testErrors != 0) testsFailed++;

    for (int n = 0; n < NumRows; n++) begin
      r          = rows[n];
      testErrors = 0;
      lsuOn      = (r.side != SideIfu);
      ifuOn      = (r.side != SideLsu);
      expXfers   = r.flush ? 0 : int'(lsuOn) + int'(ifuOn);
      @(negedge HCLK);
      countAt = slave.xferCount;
      @(posedge HCLK);
      if (lsuOn) begin
        lsuBusRW     <= r.rw;
        lsuAdr       <= r.adr;
        lsuWriteData <= r.wdata;
        lsuByteMask  <= r.mask;
        lsuFlush     <= r.flush;
        lsuStall     <= r.stall;
      end
      if (ifuOn) begin
        ifuBusRW <= BusRead;
        ifuAdr   <= lsuOn ? r.adr2 : r.adr;
        ifuFlush <= r.flush;
        ifuStall <= r.stall;
      end
      if (r.flush) begin
        // Flushed request must stay pending without reaching the bus
        repeat (10) begin
          @(negedge HCLK);
          if (lsuOn && lsuBusStall !== 1'b1)
            reportMismatch("lsuBusStall", lsuWordT'(lsuBusStall), lsuWordT'(1));
          if (ifuOn && ifuBusStall !== 1'b1)
            reportMismatch("ifuBusStall", lsuWordT'(ifuBusStall), lsuWordT'(1));
        end
      end else begin
        waitDone(lsuOn, ifuOn, r.stall, lsuAt, ifuAt);
        expIfu = lsuOn ? r.expIfu : r.expData;
        if (lsuOn && lsuAt >= 0 && r.rw == BusRead && lsuFetchBuffer !== r.expData)
          reportMismatch("lsuFetchBuffer", lsuFetchBuffer, r.expData);
        if (ifuOn && ifuAt >= 0 && lsuWordT'(ifuFetchBuffer) !== expIfu)
          reportMismatch("ifuFetchBuffer", lsuWordT'(ifuFetchBuffer), expIfu);
        if (lsuOn && ifuOn && lsuAt >= 0 && ifuAt >= 0 && lsuAt >= ifuAt)
          noteError("ifuBusStall fell no later than lsuBusStall, data side lost arbitration");
        if (r.stall) begin
          // Parked in MemDone, no restart while stalled
          repeat (5) begin
            @(negedge HCLK);
            if (lsuOn && lsuBusStall !== 1'b0)
              reportMismatch("lsuBusStall", lsuWordT'(lsuBusStall), '0);
            if (ifuOn && ifuBusStall !== 1'b0)
              reportMismatch("ifuBusStall", lsuWordT'(ifuBusStall), '0);
            if (slave.xferCount != countAt + expXfers)
              reportMismatch("xferCount", lsuWordT'(slave.xferCount),
                             lsuWordT'(countAt + expXfers));
          end
        end
      end
      @(posedge HCLK);                          // Release the requester side
      lsuBusRW <= BusNone;
      ifuBusRW <= BusNone;
      lsuStall <= 1'b0;
      ifuStall <= 1'b0;
      lsuFlush <= 1'b0;
      ifuFlush <= 1'b0;
      repeat (2) @(negedge HCLK);
      if (slave.xferCount != countAt + expXfers)
        reportMismatch("xferCount", lsuWordT'(slave.xferCount), lsuWordT'(countAt + expXfers));
      $display("Test %0d %s: %0d errors", n + 1, rowName(r), testErrors);
      if (testErrors != 0) testsFailed++;
    end

    $display("Tests run %0d, tests failed %0d, errors %0d", NumRows + 1, testsFailed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Overall run limit
  initial begin
    #100000;
    $display("Run limit of 100 us reached before the test sequence ended");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* memBus.f */
+incdir+.
ahbBusPkg.sv
busFsm.sv
ahbInterface.sv
busArbiter.sv
memBus.sv
tbAhbMemory.sv
tbMemBus.sv
